// File: Makefile
TOP = tb_dual_reservoir_neuron

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: hw/dual_reservoir_neuron.sv
`timescale 1ns/10ps

module dual_reservoir_neuron #(
   parameter int N_INPUTS = 48,
   parameter int N_LANES  = 9
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run,
   input  reservoir_pkg::state_t  state_ex [N_INPUTS],
   input  reservoir_pkg::weight_t w_ex_a [N_INPUTS],
   input  reservoir_pkg::weight_t w_ex_b [N_INPUTS],
   output reservoir_pkg::state_t  echostate_a,
   output reservoir_pkg::state_t  echostate_b,
   output logic                   echoready
);
   import reservoir_pkg::*;

   neuron_ctrl_t         ctrl;
   sop_t                 sop_a, sop_b;
   logic [LUT_IDX_W-1:0] idx_a, idx_b;
   tanh_entry_t          entry_a, entry_b;

   neuron_sequencer #(.N_INPUTS(N_INPUTS), .N_LANES(N_LANES)) u_seq (
      .clk(clk), .rst(rst), .run(run), .ctrl(ctrl), .echoready(echoready)
   );

   sop_accumulator #(.N_INPUTS(N_INPUTS), .N_LANES(N_LANES)) u_sop_a (
      .clk(clk), .rst(rst), .ctrl(ctrl),
      .state_ex(state_ex), .weights(w_ex_a), .sop(sop_a)
   );

   sop_accumulator #(.N_INPUTS(N_INPUTS), .N_LANES(N_LANES)) u_sop_b (
      .clk(clk), .rst(rst), .ctrl(ctrl),
      .state_ex(state_ex), .weights(w_ex_b), .sop(sop_b)
   );

   // both lanes share one dual-port table
   tanh_rom u_rom (
      .clk(clk), .rom_en(ctrl.rom_en),
      .idx_a(idx_a), .idx_b(idx_b),
      .entry_a(entry_a), .entry_b(entry_b)
   );

   tanh_unit u_tanh_a (
      .clk(clk), .rst(rst), .ctrl(ctrl), .sop(sop_a),
      .entry(entry_a), .lut_idx(idx_a), .echostate(echostate_a)
   );

   tanh_unit u_tanh_b (
      .clk(clk), .rst(rst), .ctrl(ctrl), .sop(sop_b),
      .entry(entry_b), .lut_idx(idx_b), .echostate(echostate_b)
   );

endmodule

// File: hw/neuron_sequencer.sv
`timescale 1ns/10ps

module neuron_sequencer #(
   parameter int N_INPUTS = 48,
   parameter int N_LANES  = 9
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        run,
   output reservoir_pkg::neuron_ctrl_t ctrl,
   output logic                        echoready
);
   import reservoir_pkg::*;

   localparam int N_BEATS = (N_INPUTS + N_LANES - 1) / N_LANES;

   typedef enum logic [2:0] {
      IDLE, MACC, REDUCE, SPLIT, ROM, PWL, OUT
   } seq_state_t;

   seq_state_t        state;
   logic [BEAT_W-1:0] beat_cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            IDLE: if (run) state <= MACC;  // run ignored elsewhere
            MACC: begin
               if (beat_cnt == BEAT_W'(N_BEATS - 1)) begin
                  beat_cnt <= '0;
                  state    <= REDUCE;
               end else begin
                  beat_cnt <= beat_cnt + 1'b1;
               end
            end
            REDUCE: state <= SPLIT;
            SPLIT:  state <= ROM;
            ROM:    state <= PWL;
            PWL:    state <= OUT;
            default: state <= IDLE;
         endcase
      end
   end

   always_comb begin
      ctrl = '0;
      case (state)
         IDLE: ctrl.clear = 1'b1;
         MACC: begin
            ctrl.macc_en = 1'b1;
            ctrl.beat    = beat_cnt;
         end
         REDUCE: ctrl.reduce_en = 1'b1;
         SPLIT:  ctrl.split_en  = 1'b1;
         ROM:    ctrl.rom_en    = 1'b1;
         PWL:    ctrl.pwl_en    = 1'b1;
         OUT:    ctrl.out_en    = 1'b1;
         default: ctrl.clear    = 1'b1;
      endcase
   end

   // lines up with the tanh output register
   always_ff @(posedge clk) begin
      if (rst) echoready <= 1'b0;
      else     echoready <= (state == OUT);
   end

   a_ready_pulse : assert property (
      @(posedge clk) disable iff (rst) echoready |=> !echoready
   );

   // beat counter only moves inside MACC and stops at the last beat
   a_state_legal : assert property (
      @(posedge clk) disable iff (rst)
         (state == MACC) ? (beat_cnt < BEAT_W'(N_BEATS)) : (beat_cnt == '0)
   );

endmodule

// File: hw/reservoir_pkg.sv
package reservoir_pkg;

   localparam int STATE_W   = 20;  // Q19
   localparam int WEIGHT_W  = 16;  // Q15
   localparam int SOP_W     = 48;  // Q34, 13 integer bits
   localparam int LUT_IDX_W = 8;   // 3Q5 segment index
   localparam int RESID_W   = 8;
   localparam int SLOPE_W   = 10;  // unsigned Q10
   localparam int ICPT_W    = 19;  // unsigned Q19
   localparam int BEAT_W    = 4;

   typedef logic signed [STATE_W-1:0]  state_t;
   typedef logic signed [WEIGHT_W-1:0] weight_t;
   typedef logic signed [SOP_W-1:0]    sop_t;

   typedef struct packed {
      logic [SLOPE_W-1:0] slope;
      logic [ICPT_W-1:0]  intercept;
   } tanh_entry_t;

   // one strobe per pipeline step, decoded from the sequencer state
   typedef struct packed {
      logic              clear;
      logic              macc_en;
      logic [BEAT_W-1:0] beat;
      logic              reduce_en;
      logic              split_en;
      logic              rom_en;
      logic              pwl_en;
      logic              out_en;
   } neuron_ctrl_t;

   localparam state_t ECHO_POS_SAT = 20'h7FFFF;  // +1 - 2^-19
   localparam state_t ECHO_NEG_SAT = 20'h80001;  // -1 + 2^-19

   // segment i covers [i/32, (i+1)/32)
   function automatic tanh_entry_t tanh_entry_at(input int i);
      real         t0;
      real         t1;
      int          icpt;
      int          slope;
      tanh_entry_t e;
      t0    = $tanh(real'(i) / 32.0);
      t1    = $tanh(real'(i + 1) / 32.0);
      icpt  = $rtoi(t0 * 524288.0 + 0.5);
      slope = $rtoi((t1 - t0) * 32.0 * 1024.0 + 0.5);
      if (icpt > (1 << ICPT_W) - 1) icpt = (1 << ICPT_W) - 1;
      if (slope > (1 << SLOPE_W) - 1) slope = (1 << SLOPE_W) - 1;
      e.slope     = slope[SLOPE_W-1:0];
      e.intercept = icpt[ICPT_W-1:0];
      return e;
   endfunction

endpackage

// File: hw/sop_accumulator.sv
`timescale 1ns/10ps

module sop_accumulator #(
   parameter int N_INPUTS = 48,
   parameter int N_LANES  = 9
) (
   input  logic                    clk,
   input  logic                    rst,
   input  reservoir_pkg::neuron_ctrl_t ctrl,
   input  reservoir_pkg::state_t   state_ex [N_INPUTS],
   input  reservoir_pkg::weight_t  weights [N_INPUTS],
   output reservoir_pkg::sop_t     sop
);
   import reservoir_pkg::*;

   localparam int N_BEATS = (N_INPUTS + N_LANES - 1) / N_LANES;
   localparam int N_PAD   = N_BEATS * N_LANES;
   localparam int PROD_W  = STATE_W + WEIGHT_W;

   state_t  st_pad [N_PAD];
   weight_t w_pad  [N_PAD];
   logic signed [PROD_W-1:0] prod [N_LANES];
   sop_t    partial [N_LANES];
   sop_t    total;

   // last beat is partial, pad it with zeros
   for (genvar k = 0; k < N_PAD; k++) begin : g_pad
      if (k < N_INPUTS) begin : g_in
         assign st_pad[k] = state_ex[k];
         assign w_pad[k]  = weights[k];
      end else begin : g_zero
         assign st_pad[k] = '0;
         assign w_pad[k]  = '0;
      end
   end

   always_comb begin
      int idx;
      for (int j = 0; j < N_LANES; j++) begin
         idx     = int'(ctrl.beat) * N_LANES + j;
         prod[j] = st_pad[idx] * w_pad[idx];  // Q34, 36 bits
      end
   end

   always_ff @(posedge clk) begin
      if (rst || ctrl.clear) begin
         for (int j = 0; j < N_LANES; j++) partial[j] <= '0;
      end else if (ctrl.macc_en) begin
         for (int j = 0; j < N_LANES; j++) begin
            partial[j] <= partial[j] + sop_t'(prod[j]);
         end
      end
   end

   // single-cycle reduce of the lane sums
   always_comb begin
      total = '0;
      for (int j = 0; j < N_LANES; j++) total = total + partial[j];
   end

   always_ff @(posedge clk) begin
      if (ctrl.reduce_en) sop <= total;
   end

endmodule

// File: hw/tanh_rom.sv
`timescale 1ns/10ps

module tanh_rom (
   input  logic                                clk,
   input  logic                                rom_en,
   input  logic [reservoir_pkg::LUT_IDX_W-1:0] idx_a,
   input  logic [reservoir_pkg::LUT_IDX_W-1:0] idx_b,
   output reservoir_pkg::tanh_entry_t          entry_a,
   output reservoir_pkg::tanh_entry_t          entry_b
);
   import reservoir_pkg::*;

   localparam int DEPTH = 1 << LUT_IDX_W;

   tanh_entry_t table_q [DEPTH];

   // slope/intercept pairs over 0..8 in 1/32 steps
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         table_q[i] = tanh_entry_at(i);
      end
   end

   // port a serves lane a, port b lane b
   always_ff @(posedge clk) begin
      if (rom_en) begin
         entry_a <= table_q[idx_a];
         entry_b <= table_q[idx_b];
      end
   end

endmodule

// File: hw/tanh_unit.sv
`timescale 1ns/10ps

module tanh_unit (
   input  logic                                 clk,
   input  logic                                 rst,
   input  reservoir_pkg::neuron_ctrl_t          ctrl,
   input  reservoir_pkg::sop_t                  sop,
   input  reservoir_pkg::tanh_entry_t           entry,
   output logic [reservoir_pkg::LUT_IDX_W-1:0]  lut_idx,
   output reservoir_pkg::state_t                echostate
);
   import reservoir_pkg::*;

   localparam int PWL_W = ICPT_W + 5;  // Q23 plus headroom bit

   logic [SOP_W-1:0]   sop_abs;
   logic               sign_q;
   logic               large_q;
   logic [RESID_W-1:0] resid_q;
   logic [PWL_W-1:0]   pwl_q;
   logic [STATE_W-1:0] mag;

   assign sop_abs = sop[SOP_W-1] ? -sop : sop;

   // split stage
   always_ff @(posedge clk) begin
      if (rst) begin
         sign_q  <= 1'b0;
         large_q <= 1'b0;
      end else if (ctrl.split_en) begin
         sign_q  <= sop[SOP_W-1];
         large_q <= |sop_abs[47:37];  // |sop| >= 8.0
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.split_en) begin
         lut_idx <= sop_abs[36:29];  // 3Q5 segment
         resid_q <= sop_abs[28:21];  // position inside segment, Q13
      end
   end

   // intercept Q19 -> Q23 plus slope Q10 * resid Q13 = Q23
   always_ff @(posedge clk) begin
      if (ctrl.pwl_en) begin
         pwl_q <= PWL_W'({entry.intercept, 4'b0000})
                + PWL_W'(entry.slope) * PWL_W'(resid_q);
      end
   end

   assign mag = pwl_q[23:4];  // back to Q19

   // output stage with sign and saturation
   always_ff @(posedge clk) begin
      if (rst) begin
         echostate <= '0;
      end else if (ctrl.out_en) begin
         if (large_q) begin
            echostate <= sign_q ? ECHO_NEG_SAT : ECHO_POS_SAT;
         end else begin
            echostate <= sign_q ? -mag : mag;
         end
      end
   end

   // table never reaches 1.0, so the most negative code must not appear
   a_no_min_code : assert property (
      @(posedge clk) disable iff (rst) echostate != 20'h80000
   );

endmodule

// File: sim.f
hw/reservoir_pkg.sv
hw/sop_accumulator.sv
hw/tanh_rom.sv
hw/tanh_unit.sv
hw/neuron_sequencer.sv
hw/dual_reservoir_neuron.sv
verification/tb_dual_reservoir_neuron.sv

// File: verification/dual_neuron_tests.txt
// columns: n state w_a w_b echo_a echo_b, all hex, elements past n are zero
// state and echo values are Q19, weights Q15, saturation gives 7FFFF or 80001
00 7FFFF 7FFF 7FFF 00000 00000
01 40000 4000 C000 1F598 E0A68
02 40000 4000 2000 3B26A 1F598
04 C0000 2000 4000 C4D96 9E841
30 7FFFF 7FFF 8000 7FFFF 80001
09 7FFFF 7FFF 0000 7FFFF 00000
10 80000 7FFF 8000 80001 7FFFF

// File: verification/tb_dual_reservoir_neuron.sv
`timescale 1ns/10ps

module tb_dual_reservoir_neuron;
   import reservoir_pkg::*;

   localparam int N_INPUTS   = 48;
   localparam int N_LANES    = 9;
   localparam int N_DIR      = 7;   // rows in the tests file
   localparam int N_COLS     = 6;
   localparam int N_RAND     = 20;
   localparam int LATENCY    = 11;  // beats + 5
   localparam int MAX_CYCLES = (N_DIR + N_RAND + 2) * 20;

   logic    clk;
   logic    rst;
   logic    run;
   state_t  state_ex [N_INPUTS];
   weight_t w_ex_a   [N_INPUTS];
   weight_t w_ex_b   [N_INPUTS];
   state_t  echostate_a;
   state_t  echostate_b;
   logic    echoready;

   logic [19:0] test_words [N_DIR*N_COLS];
   logic [31:0] lfsr;
   int          cycles = 0;

   dual_reservoir_neuron #(.N_INPUTS(N_INPUTS), .N_LANES(N_LANES)) u_dut (
      .clk(clk), .rst(rst), .run(run),
      .state_ex(state_ex), .w_ex_a(w_ex_a), .w_ex_b(w_ex_b),
      .echostate_a(echostate_a), .echostate_b(echostate_b), .echoready(echoready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $fatal(1, "simulation hung");
      end
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] v);
      return v[0] ? ((v >> 1) ^ 32'h80200003) : (v >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         bits = {bits[30:0], lfsr[0]};
      end
   endtask

   function automatic longint model_sop(input bit lane_b);
      longint acc;
      acc = 0;
      for (int k = 0; k < N_INPUTS; k++) begin
         acc += longint'(state_ex[k]) * longint'(lane_b ? w_ex_b[k] : w_ex_a[k]);
      end
      return acc;  // Q34
   endfunction

   // segment lookup plus linear step, table rebuilt here from $tanh
   function automatic state_t model_echo(input longint sop);
      longint      mag;
      longint      icpt;
      longint      slope;
      longint      pwl;
      int          idx;
      int          resid;
      logic [19:0] m;
      mag = (sop < 0) ? -sop : sop;
      if (mag >= (longint'(1) << 37)) return (sop < 0) ? 20'h80001 : 20'h7FFFF;
      idx   = int'((mag >> 29) & 255);
      resid = int'((mag >> 21) & 255);
      icpt  = $rtoi($tanh(idx / 32.0) * 524288.0 + 0.5);
      slope = $rtoi(($tanh((idx + 1) / 32.0) - $tanh(idx / 32.0)) * 32768.0 + 0.5);
      if (icpt > 524287) icpt = 524287;
      if (slope > 1023) slope = 1023;
      pwl = icpt * 16 + slope * resid;  // Q23
      m   = pwl[23:4];
      return (sop < 0) ? -m : m;
   endfunction

   task automatic check_echo(input string name, input state_t got, input state_t exp);
      if (got !== exp) begin
         $display("Error: %s = 0x%05h, expected 0x%05h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "echostate mismatch");
      end
   endtask

   task automatic check_ready(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: echoready = 0x%0h, expected 0x%0h", got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "echoready mismatch");
      end
   endtask

   // first n elements carry the row values
   task automatic load_uniform(input int n, input state_t s, input weight_t wa,
                               input weight_t wb);
      @(posedge clk);
      for (int k = 0; k < N_INPUTS; k++) begin
         state_ex[k] <= (k < n) ? s : '0;
         w_ex_a[k]   <= (k < n) ? wa : '0;
         w_ex_b[k]   <= (k < n) ? wb : '0;
      end
   endtask

   task automatic load_random();
      logic [31:0] bits;
      @(posedge clk);
      for (int k = 0; k < N_INPUTS; k++) begin
         take_bits(STATE_W, bits);
         state_ex[k] <= bits[STATE_W-1:0];
         take_bits(WEIGHT_W, bits);
         w_ex_a[k] <= bits[WEIGHT_W-1:0];
         take_bits(WEIGHT_W, bits);
         w_ex_b[k] <= bits[WEIGHT_W-1:0];
      end
   endtask

   // ready only on the 11th edge after run is taken
   task automatic run_and_check(input state_t exp_a, input state_t exp_b, input bit busy_pulse);
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      for (int k = 1; k <= LATENCY; k++) begin
         @(posedge clk);
         run <= busy_pulse && (k == 3);  // must be ignored
         @(negedge clk);
         check_ready(echoready, k == LATENCY);
      end
      check_echo("echostate_a", echostate_a, exp_a);
      check_echo("echostate_b", echostate_b, exp_b);
      for (int k = 0; k < (busy_pulse ? 12 : 1); k++) begin
         @(negedge clk);
         check_ready(echoready, 1'b0);
         check_echo("echostate_a", echostate_a, exp_a);
         check_echo("echostate_b", echostate_b, exp_b);
      end
   endtask

   initial begin
      int     base;
      state_t exp_a;
      state_t exp_b;
      rst  = 1'b1;
      run  = 1'b0;
      lfsr = 32'h3c542ced;
      for (int k = 0; k < N_INPUTS; k++) begin
         state_ex[k] = '0;
         w_ex_a[k]   = '0;
         w_ex_b[k]   = '0;
      end
      $readmemh("verification/dual_neuron_tests.txt", test_words);
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      repeat (3) begin
         @(negedge clk);
         check_ready(echoready, 1'b0);
         check_echo("echostate_a", echostate_a, '0);
         check_echo("echostate_b", echostate_b, '0);
      end
      for (int r = 0; r < N_DIR; r++) begin
         base = r * N_COLS;
         load_uniform(int'(test_words[base]), test_words[base+1],
                      test_words[base+2][15:0], test_words[base+3][15:0]);
         run_and_check(test_words[base+4], test_words[base+5], r == 1);
      end
      for (int t = 0; t < N_RAND; t++) begin
         load_random();
         @(negedge clk);  // vectors settled
         exp_a = model_echo(model_sop(1'b0));
         exp_b = model_echo(model_sop(1'b1));
         run_and_check(exp_a, exp_b, 1'b0);
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
